// ==== design/sha_framer_cfg.svh ====
//--------------------------------------------------------------------
// SHA-512 message framer widths
// Fixed sizes of the message word, the 1024-bit block, the bit-length
// field and the byte offset where the length no longer fits
//--------------------------------------------------------------------
`ifndef SHA_FRAMER_CFG_SVH
`define SHA_FRAMER_CFG_SVH

// Width of one message word from the host
`define SHA_WORD_W 32

// One SHA-512 message block
`define SHA_BLOCK_W 1024
`define SHA_WORDS_PER_BLOCK 32

// The bit length of the message sits in the last 128 bits of the final block
`define SHA_LEN_FIELD_W 128

// Data ending at this byte offset or later pushes the length into an extra block
`define SHA_PAD_LIMIT 112

// Width of the byte length given at start
`define SHA_MSG_LEN_W 32

`endif

// ==== design/sha_framer_pkg.sv ====
//--------------------------------------------------------------------
// SHA-512 message framer types and stage interfaces
// Vector types shared by the stages, the sequencer state encoding, and
// the word and block bundles that link intake, builder and sender
//--------------------------------------------------------------------
`include "sha_framer_cfg.svh"

package sha_framer_pkg;

  // One big-endian message word, first byte in bits 31:24
  typedef logic [`SHA_WORD_W-1:0] word_t;

  // One message block with word 0 in the top bits
  typedef logic [`SHA_BLOCK_W-1:0] block_t;

  // Message length in bytes
  typedef logic [`SHA_MSG_LEN_W-1:0] msg_len_t;

  // Block write pointer, the extra top bit flags a full block
  typedef logic [$clog2(`SHA_WORDS_PER_BLOCK):0] word_idx_t;

  // Byte offset inside one block
  typedef logic [$clog2(`SHA_BLOCK_W/8)-1:0] byte_off_t;

  // Sequencer states
  typedef enum logic [2:0] {
    FRAME_IDLE    = 3'd0,
    FRAME_BLOCK_0 = 3'd1,
    FRAME_BLOCK_N = 3'd2,
    FRAME_PAD0    = 3'd3,
    FRAME_PAD1    = 3'd4,
    FRAME_DONE    = 3'd5
  } frame_state_e;

endpackage

//--------------------------------------------------------------------
// Word path from the intake into the block register
//--------------------------------------------------------------------
interface word_if;
  import sha_framer_pkg::*;

  logic     word_we;
  word_t    word_data;
  // Length latched at start, used for padding long after start has gone
  msg_len_t msg_len;
  logic     msg_end;
  logic     block_full;

  modport intake (output word_we, word_data, msg_len, msg_end, input block_full);
  modport builder (input word_we, word_data, output block_full);
endinterface

//--------------------------------------------------------------------
// Finished block from the builder to the output sender
//--------------------------------------------------------------------
interface blk_if;
  import sha_framer_pkg::*;

  logic   blk_load;
  block_t blk_data;
  logic   blk_first;
  logic   blk_last;
  logic   blk_taken;

  modport builder (output blk_load, blk_data, blk_first, blk_last);
  modport sender (input blk_load, blk_data, blk_first, blk_last, output blk_taken);
endinterface

// ==== design/sha_word_intake.sv ====
//--------------------------------------------------------------------
// Message word intake
// Four-phase slave for the host data words; latches the message length
// and counts received bytes to flag the end of the message
//--------------------------------------------------------------------
`include "sha_framer_cfg.svh"

module sha_word_intake (
  input  logic                     clk,
  input  logic                     rst_b,
  input  logic                     start,
  input  sha_framer_pkg::msg_len_t msg_len,
  input  logic                     data_req,
  input  sha_framer_pkg::word_t    data_word,
  output logic                     data_ack,
  word_if.intake                   wr
);

  import sha_framer_pkg::*;

  // Length of the current message and bytes taken so far
  msg_len_t len_q;
  msg_len_t byte_cnt_q;
  logic     msg_end;
  logic     take_word;
  logic     start_ok;

  // The count runs in whole words, so the last word may overshoot the length
  assign msg_end = (byte_cnt_q >= len_q);

  // A new message only restarts the count once the previous one has all its words
  assign start_ok = start & msg_end;

  // A word is taken on the edge where ack rises
  // No ack while the block is full or after the last word has arrived
  assign take_word = data_req & ~data_ack & ~wr.block_full & ~msg_end;

  //------------------------------------------------------------------
  // Length and byte count
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      len_q      <= '0;
      byte_cnt_q <= '0;
    end else if (start_ok) begin
      len_q      <= msg_len;
      byte_cnt_q <= '0;
    end else if (take_word) begin
      byte_cnt_q <= byte_cnt_q + msg_len_t'(`SHA_WORD_W / 8);
    end
  end

  //------------------------------------------------------------------
  // Four-phase slave
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      data_ack <= 1'b0;
    end else if (!data_ack) begin
      // Raise ack one cycle after req, only when the word can be written
      if (take_word) begin
        data_ack <= 1'b1;
      end
    end else if (!data_req) begin
      // Host has dropped req, so close the handshake
      data_ack <= 1'b0;
    end
  end

  // Word goes to the block register on the same edge that raises ack
  assign wr.word_we   = take_word;
  assign wr.word_data = data_word;
  assign wr.msg_len   = len_q;
  assign wr.msg_end   = msg_end;

endmodule

// ==== design/sha_block_builder.sv ====
//--------------------------------------------------------------------
// SHA-512 block builder
// Holds the 32-word block register and its write pointer, and applies
// the end-of-message padding and the 128-bit length field
//--------------------------------------------------------------------
`include "sha_framer_cfg.svh"

module sha_block_builder (
  input  logic                     clk,
  input  logic                     rst_b,
  word_if.builder                  wr,
  input  sha_framer_pkg::msg_len_t msg_len,
  input  logic                     clear_ptr,
  input  logic                     pad_cmd,
  input  logic                     len_cmd,
  input  logic                     emit,
  input  logic                     first,
  input  logic                     last,
  output logic                     extra_pad,
  blk_if.builder                   out
);

  import sha_framer_pkg::*;

  localparam int WORD_IDX_W = $clog2(`SHA_WORDS_PER_BLOCK);

  word_idx_t wptr_q;
  block_t    blk_q;

  // Padding terms
  byte_off_t                   data_bytes;
  logic [9:0]                  byte_shift;
  logic [`SHA_LEN_FIELD_W-1:0] len_bits;
  block_t                      keep_mask;
  block_t                      pad_marker;
  block_t                      pad_blk;
  block_t                      len_blk;

  //------------------------------------------------------------------
  // Write pointer
  //------------------------------------------------------------------
  // The pointer runs one past the last word, and its top bit is the full flag
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wptr_q <= '0;
    end else if (clear_ptr) begin
      wptr_q <= '0;
    end else if (wr.word_we) begin
      wptr_q <= wptr_q + word_idx_t'(1);
    end
  end

  assign wr.block_full = wptr_q[WORD_IDX_W];

  //------------------------------------------------------------------
  // Padding
  //------------------------------------------------------------------
  // Bytes of message data in the final block
  assign data_bytes = byte_off_t'(msg_len);

  // When the data reaches byte 112 the length needs a block of its own
  assign extra_pad = (data_bytes >= `SHA_PAD_LIMIT);

  // Shift in bits, wide enough for a whole block of bytes
  assign byte_shift = {data_bytes, 3'b000};

  // Message length in bits, right-aligned in the 128-bit field
  assign len_bits = {{(`SHA_LEN_FIELD_W - `SHA_MSG_LEN_W - 3){1'b0}}, msg_len, 3'b000};

  // Second pad block is all zero apart from the length
  assign len_blk = {{(`SHA_BLOCK_W - `SHA_LEN_FIELD_W){1'b0}}, len_bits};

  always_comb begin
    // Ones over the data bytes, which sit at the top of the block
    keep_mask  = ~({`SHA_BLOCK_W{1'b1}} >> byte_shift);
    // Pad byte lands on the first byte past the data
    pad_marker = {8'h80, {(`SHA_BLOCK_W - 8){1'b0}}} >> byte_shift;
    pad_blk    = (blk_q & keep_mask) | pad_marker;
    // Length goes in the low 16 bytes when the data leaves room for it
    if (!extra_pad) begin
      pad_blk[`SHA_LEN_FIELD_W-1:0] = len_bits;
    end
  end

  //------------------------------------------------------------------
  // Block register
  //------------------------------------------------------------------
  // The intake never writes while a pad command is issued
  always_ff @(posedge clk) begin
    if (wr.word_we) begin
      blk_q[`SHA_BLOCK_W - 1 - `SHA_WORD_W * wptr_q[WORD_IDX_W-1:0] -: `SHA_WORD_W]
        <= wr.word_data;
    end else if (pad_cmd) begin
      blk_q <= pad_blk;
    end else if (len_cmd) begin
      blk_q <= len_blk;
    end
  end

  // Sender copies the block and its flags when emit is high
  assign out.blk_load  = emit;
  assign out.blk_data  = blk_q;
  assign out.blk_first = first;
  assign out.blk_last  = last;

endmodule

// ==== design/sha_frame_ctrl.sv ====
//--------------------------------------------------------------------
// SHA-512 framing sequencer
// Steps a message through its data blocks and pad blocks, and hands
// each finished block to the sender one at a time
//--------------------------------------------------------------------
module sha_frame_ctrl (
  input  logic clk,
  input  logic rst_b,
  input  logic start,
  input  logic block_full,
  input  logic msg_end,
  input  logic extra_pad,
  input  logic blk_taken,
  output logic clear_ptr,
  output logic pad_cmd,
  output logic len_cmd,
  output logic emit,
  output logic first,
  output logic last,
  output logic busy
);

  import sha_framer_pkg::*;

  frame_state_e state_q;
  frame_state_e state_nxt;

  // High from emit until the receiver has taken the block
  logic pending_q;
  logic pending_nxt;

  // The pad block is also the first block when the message fits in one
  logic pad_first_q;

  always_comb begin
    state_nxt   = state_q;
    pending_nxt = pending_q;
    clear_ptr   = 1'b0;
    pad_cmd     = 1'b0;
    len_cmd     = 1'b0;
    emit        = 1'b0;
    first       = 1'b0;
    last        = 1'b0;

    case (state_q)
      // A new message may start in DONE as well, since busy is already low
      FRAME_IDLE, FRAME_DONE: begin
        state_nxt = FRAME_IDLE;
        if (start) begin
          state_nxt   = FRAME_BLOCK_0;
          clear_ptr   = 1'b1;
          pending_nxt = 1'b0;
        end
      end
      FRAME_BLOCK_0, FRAME_BLOCK_N: begin
        first = (state_q == FRAME_BLOCK_0);
        if (pending_q) begin
          // Block is gone, so the register is free for the next words
          if (blk_taken) begin
            clear_ptr   = 1'b1;
            pending_nxt = 1'b0;
            state_nxt   = FRAME_BLOCK_N;
          end
        end else if (block_full) begin
          emit        = 1'b1;
          pending_nxt = 1'b1;
        end else if (msg_end) begin
          // All words are in and the block has room, so pad it in place
          pad_cmd   = 1'b1;
          state_nxt = FRAME_PAD0;
        end
      end
      FRAME_PAD0: begin
        first = pad_first_q;
        last  = ~extra_pad;
        if (!pending_q) begin
          // Padded block was written on the edge into this state
          emit        = 1'b1;
          pending_nxt = 1'b1;
        end else if (blk_taken) begin
          pending_nxt = 1'b0;
          if (extra_pad) begin
            // Length block is written on the way into PAD1
            len_cmd   = 1'b1;
            state_nxt = FRAME_PAD1;
          end else begin
            state_nxt = FRAME_DONE;
          end
        end
      end
      FRAME_PAD1: begin
        last = 1'b1;
        if (!pending_q) begin
          emit        = 1'b1;
          pending_nxt = 1'b1;
        end else if (blk_taken) begin
          pending_nxt = 1'b0;
          state_nxt   = FRAME_DONE;
        end
      end
      default: begin
        state_nxt   = FRAME_IDLE;
        pending_nxt = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q     <= FRAME_IDLE;
      pending_q   <= 1'b0;
      pad_first_q <= 1'b0;
    end else begin
      state_q   <= state_nxt;
      pending_q <= pending_nxt;
      if (pad_cmd) begin
        pad_first_q <= (state_q == FRAME_BLOCK_0);
      end
    end
  end

  // Busy drops on entry to DONE, one cycle after the last ack falls
  assign busy = (state_q != FRAME_IDLE) && (state_q != FRAME_DONE);

endmodule

// ==== design/sha_block_sender.sv ====
//--------------------------------------------------------------------
// SHA-512 block sender
// Four-phase master that holds a finished block and its flags stable
// until the receiver has completed the handshake
//--------------------------------------------------------------------
module sha_block_sender (
  input  logic                   clk,
  input  logic                   rst_b,
  blk_if.sender                  in,
  input  logic                   blk_ack,
  output logic                   blk_req,
  output sha_framer_pkg::block_t blk_data,
  output logic                   blk_first,
  output logic                   blk_last
);

  // Req has dropped and the receiver has yet to release ack
  logic wait_low_q;

  //------------------------------------------------------------------
  // Block and flag hold registers
  //------------------------------------------------------------------
  // Loaded only at blk_load, so they stay stable through the whole handshake
  always_ff @(posedge clk) begin
    if (in.blk_load) begin
      blk_data  <= in.blk_data;
      blk_first <= in.blk_first;
      blk_last  <= in.blk_last;
    end
  end

  //------------------------------------------------------------------
  // Four-phase master
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      blk_req    <= 1'b0;
      wait_low_q <= 1'b0;
    end else if (in.blk_load) begin
      // Req rises on the cycle after the load
      blk_req <= 1'b1;
    end else if (blk_req && blk_ack) begin
      blk_req    <= 1'b0;
      wait_low_q <= 1'b1;
    end else if (wait_low_q && !blk_ack) begin
      wait_low_q <= 1'b0;
    end
  end

  // Single pulse in the cycle the released ack is first seen
  assign in.blk_taken = wait_low_q & ~blk_ack;

endmodule

// ==== design/sha_msg_framer.sv ====
//--------------------------------------------------------------------
// SHA-512 message framer
// Turns a stream of 32-bit host words into padded 1024-bit blocks,
// each offered to the hash core over a four-phase handshake
//--------------------------------------------------------------------
module sha_msg_framer (
  input  logic                     clk,
  input  logic                     rst_b,
  // Message start, msg_len is sampled with the start pulse
  input  logic                     start,
  input  sha_framer_pkg::msg_len_t msg_len,
  // Host word handshake
  input  logic                     data_req,
  input  sha_framer_pkg::word_t    data_word,
  output logic                     data_ack,
  // Block handshake towards the core
  output logic                     blk_req,
  input  logic                     blk_ack,
  output sha_framer_pkg::block_t   blk_data,
  output logic                     blk_first,
  output logic                     blk_last,
  output logic                     busy
);

  // Sequencer commands to the builder
  logic clear_ptr;
  logic pad_cmd;
  logic len_cmd;
  logic emit;
  logic first;
  logic last;
  logic extra_pad;

  word_if word_bus ();
  blk_if  blk_bus ();

  sha_word_intake i_word_intake (
    .clk       (clk),
    .rst_b     (rst_b),
    .start     (start),
    .msg_len   (msg_len),
    .data_req  (data_req),
    .data_word (data_word),
    .data_ack  (data_ack),
    .wr        (word_bus)
  );

  // Builder pads against the length latched by the intake
  sha_block_builder i_block_builder (
    .clk       (clk),
    .rst_b     (rst_b),
    .wr        (word_bus),
    .msg_len   (word_bus.msg_len),
    .clear_ptr (clear_ptr),
    .pad_cmd   (pad_cmd),
    .len_cmd   (len_cmd),
    .emit      (emit),
    .first     (first),
    .last      (last),
    .extra_pad (extra_pad),
    .out       (blk_bus)
  );

  sha_frame_ctrl i_frame_ctrl (
    .clk        (clk),
    .rst_b      (rst_b),
    .start      (start),
    .block_full (word_bus.block_full),
    .msg_end    (word_bus.msg_end),
    .extra_pad  (extra_pad),
    .blk_taken  (blk_bus.blk_taken),
    .clear_ptr  (clear_ptr),
    .pad_cmd    (pad_cmd),
    .len_cmd    (len_cmd),
    .emit       (emit),
    .first      (first),
    .last       (last),
    .busy       (busy)
  );

  sha_block_sender i_block_sender (
    .clk       (clk),
    .rst_b     (rst_b),
    .in        (blk_bus),
    .blk_ack   (blk_ack),
    .blk_req   (blk_req),
    .blk_data  (blk_data),
    .blk_first (blk_first),
    .blk_last  (blk_last)
  );

endmodule

// ==== dv/tb_sha_msg_framer.sv ====
//--------------------------------------------------------------------
// SHA-512 message framer testbench
// Host driver, core responder and reference padder around the framer,
// with one directed task per message shape
//--------------------------------------------------------------------
`include "sha_framer_cfg.svh"

module tb_sha_msg_framer;

  import sha_framer_pkg::*;

  localparam int BLK_BYTES = `SHA_BLOCK_W / 8;
  localparam int WAIT_MAX  = 4000;

  logic     clk;
  logic     rst_b;
  logic     start;
  msg_len_t msg_len;
  logic     data_req;
  word_t    data_word;
  logic     data_ack;
  logic     blk_req;
  logic     blk_ack;
  block_t   blk_data;
  logic     blk_first;
  logic     blk_last;
  logic     busy;

  logic [31:0] rng_state;
  int          err_count;
  int          test_count;
  int          fail_count;

  // Message bytes, reference blocks and what the responder collected
  logic [7:0] msg_bytes [1024];
  block_t     exp_blk [8];
  block_t     got_blk [8];
  logic       got_first [8];
  logic       got_last [8];
  int         n_exp;
  int         n_got;

  sha_msg_framer i_sha_msg_framer (
    .clk       (clk),
    .rst_b     (rst_b),
    .start     (start),
    .msg_len   (msg_len),
    .data_req  (data_req),
    .data_word (data_word),
    .data_ack  (data_ack),
    .blk_req   (blk_req),
    .blk_ack   (blk_ack),
    .blk_data  (blk_data),
    .blk_first (blk_first),
    .blk_last  (blk_last),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Linear congruential generator for message bytes and ack delays
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic report_timeout(input string name, input string what);
    $display("TIMEOUT in %s: %s", name, what);
    err_count++;
  endtask

  // Every byte is random, so the tail of the final word carries junk
  task automatic fill_message();
    logic [31:0] r;
    for (int i = 0; i < 1024; i++) begin
      r = next_rand();
      msg_bytes[i] = r[31:24];
    end
  endtask

  //------------------------------------------------------------------
  // Reference padder
  //------------------------------------------------------------------
  // Message, then 8'h80, then zeros up to a multiple of 128 bytes that
  // leaves room for the 128-bit big-endian bit length at the very end
  task automatic build_expected(input int len);
    logic [7:0]   pad [1024];
    logic [127:0] len_bits;
    int           total;
    n_exp    = (len + 17 + BLK_BYTES - 1) / BLK_BYTES;
    total    = n_exp * BLK_BYTES;
    len_bits = {96'd0, 32'(len)} << 3;
    for (int i = 0; i < total; i++) begin
      pad[i] = (i < len) ? msg_bytes[i] : ((i == len) ? 8'h80 : 8'h00);
    end
    for (int m = 0; m < 16; m++) begin
      pad[total - 16 + m] = len_bits[127 - 8 * m -: 8];
    end
    // Byte 0 of each block goes to the top bits
    for (int j = 0; j < n_exp; j++) begin
      for (int k = 0; k < BLK_BYTES; k++) begin
        exp_blk[j][`SHA_BLOCK_W - 1 - 8 * k -: 8] = pad[j * BLK_BYTES + k];
      end
    end
  endtask

  //------------------------------------------------------------------
  // Host driver
  //------------------------------------------------------------------
  task automatic send_message(input string name, input int len);
    int t;
    @(posedge clk);
    start   <= 1'b1;
    msg_len <= 32'(len);
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    if (!busy) begin
      $display("ERROR in %s: busy did not rise after start", name);
      err_count++;
    end
    for (int w = 0; w < (len + 3) / 4; w++) begin
      @(posedge clk);
      data_word <= {msg_bytes[4*w], msg_bytes[4*w+1], msg_bytes[4*w+2], msg_bytes[4*w+3]};
      data_req  <= 1'b1;
      t = 0;
      @(negedge clk);
      while (!data_ack && t < WAIT_MAX) begin
        @(negedge clk);
        t++;
      end
      @(posedge clk);
      data_req <= 1'b0;
      if (!data_ack) begin
        report_timeout(name, "the framer never acknowledged a message word");
        return;
      end
      t = 0;
      @(negedge clk);
      while (data_ack && t < WAIT_MAX) begin
        @(negedge clk);
        t++;
      end
      if (data_ack) begin
        report_timeout(name, "data_ack stayed high after req was dropped");
        return;
      end
    end
  endtask

  //------------------------------------------------------------------
  // Responder playing the hash core
  //------------------------------------------------------------------
  task automatic collect_blocks(input string name, input int max_delay);
    logic [31:0] r;
    int          t;
    n_got = 0;
    for (int b = 0; b < n_exp; b++) begin
      t = 0;
      @(negedge clk);
      while (!blk_req && t < WAIT_MAX) begin
        @(negedge clk);
        t++;
      end
      if (!blk_req) begin
        report_timeout(name, "no blk_req for the next block");
        return;
      end
      r = next_rand();
      repeat (int'(r[15:0]) % (max_delay + 1)) @(negedge clk);
      got_blk[b]   = blk_data;
      got_first[b] = blk_first;
      got_last[b]  = blk_last;
      n_got++;
      if (!busy) begin
        $display("ERROR in %s: busy low while block %0d is offered", name, b);
        err_count++;
      end
      @(posedge clk);
      blk_ack <= 1'b1;
      t = 0;
      @(negedge clk);
      while (blk_req && t < WAIT_MAX) begin
        @(negedge clk);
        t++;
      end
      @(posedge clk);
      blk_ack <= 1'b0;
      if (blk_req) begin
        report_timeout(name, "blk_req stayed high after ack");
        return;
      end
    end
  endtask

  //------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------
  task automatic compare_blocks(input string name);
    if (n_got != n_exp) begin
      $display("MISMATCH %s: block count expected %0d actual %0d", name, n_exp, n_got);
      err_count++;
    end
    for (int b = 0; b < n_got && b < n_exp; b++) begin
      if (got_blk[b] !== exp_blk[b]) begin
        $display("MISMATCH %s: block %0d data expected %h actual %h",
                 name, b, exp_blk[b], got_blk[b]);
        err_count++;
      end
      if (got_first[b] !== (b == 0) || got_last[b] !== (b == n_exp - 1)) begin
        $display("MISMATCH %s: block %0d first/last expected %b%b actual %b%b",
                 name, b, (b == 0), (b == n_exp - 1), got_first[b], got_last[b]);
        err_count++;
      end
    end
  endtask

  // Busy falls one cycle after the last ack, and no further block follows
  task automatic expect_idle(input string name);
    int t;
    t = 0;
    @(negedge clk);
    while (busy && t < 8) begin
      @(negedge clk);
      t++;
    end
    if (busy) begin
      report_timeout(name, "busy stayed high after the last block");
    end
    if (blk_req) begin
      $display("ERROR in %s: blk_req raised after the last block", name);
      err_count++;
    end
  endtask

  task automatic check_pad_byte(input string name, input int blk, input int byte_idx);
    if (blk >= n_got) begin
      $display("ERROR in %s: block %0d was never received", name, blk);
      err_count++;
    end else if (got_blk[blk][`SHA_BLOCK_W - 1 - 8 * byte_idx -: 8] !== 8'h80) begin
      $display("MISMATCH %s: pad byte %0d expected 80 actual %h", name, byte_idx,
               got_blk[blk][`SHA_BLOCK_W - 1 - 8 * byte_idx -: 8]);
      err_count++;
    end
  endtask

  task automatic check_length(input string name, input int blk, input int bits);
    if (blk < n_got && got_blk[blk][127:0] !== 128'(bits)) begin
      $display("MISMATCH %s: bit length expected %0d actual %0d", name, bits,
               got_blk[blk][127:0]);
      err_count++;
    end
  endtask

  // One full message through the framer against the reference blocks
  task automatic frame_message(input string name, input int len, input int max_delay);
    fill_message();
    build_expected(len);
    fork
      send_message(name, len);
      collect_blocks(name, max_delay);
    join
    compare_blocks(name);
    expect_idle(name);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", name, err_count - errs_before);
    end
  endtask

  //------------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------------
  task automatic three_byte_message();
    int e;
    e = err_count;
    frame_message("three_byte", 3, 4);
    check_pad_byte("three_byte", 0, 3);
    check_length("three_byte", 0, 24);
    report_test("three_byte", e);
  endtask

  // 120 data bytes leave no room, so the length moves to a block of its own
  task automatic two_block_pad();
    int e;
    e = err_count;
    frame_message("len_120", 120, 4);
    check_pad_byte("len_120", 0, 120);
    check_length("len_120", 1, 960);
    report_test("len_120", e);
  endtask

  task automatic three_block_random();
    int e;
    e = err_count;
    frame_message("len_300", 300, 6);
    check_pad_byte("len_300", 2, 44);
    report_test("len_300", e);
  endtask

  task automatic aligned_extra_pad();
    int e;
    e = err_count;
    frame_message("len_256", 256, 4);
    check_pad_byte("len_256", 2, 0);
    check_length("len_256", 2, 2048);
    report_test("len_256", e);
  endtask

  task automatic empty_message();
    int e;
    e = err_count;
    frame_message("zero_len", 0, 4);
    check_pad_byte("zero_len", 0, 0);
    check_length("zero_len", 0, 0);
    report_test("zero_len", e);
  endtask

  // Long ack delays keep full blocks waiting and stall the host
  task automatic slow_receiver();
    int e;
    e = err_count;
    frame_message("back_pressure", 500, 60);
    check_length("back_pressure", 4, 4000);
    report_test("back_pressure", e);
  endtask

  initial begin
    rng_state  = 32'hb8d4_ceef;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    rst_b      = 1'b0;
    start      = 1'b0;
    msg_len    = '0;
    data_req   = 1'b0;
    data_word  = '0;
    blk_ack    = 1'b0;
    repeat (16) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    if (data_ack || blk_req || busy) begin
      $display("ERROR after reset: data_ack, blk_req or busy is high");
      err_count++;
    end
    three_byte_message();
    two_block_pad();
    three_block_random();
    aligned_extra_pad();
    empty_message();
    slow_receiver();
    $display("tests run %0d, tests failing %0d, errors %0d", test_count, fail_count,
             err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/sha_framer_pkg.sv
design/sha_word_intake.sv
design/sha_block_builder.sv
design/sha_frame_ctrl.sv
design/sha_block_sender.sv
design/sha_msg_framer.sv
dv/tb_sha_msg_framer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SHA-512 framer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_sha_msg_framer -f verilog.f -Mdir obj_dir \
  && ./obj_dir/Vtb_sha_msg_framer > sim.log 2>&1 \
  || echo "build or simulation error"
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log 2>/dev/null && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
